/* verilog/hpdcache_pkg.sv */
package hpdcache_pkg;

    // Request identifier echoed back on every result strobe
    localparam int unsigned HPDCACHE_ID_WIDTH = 4;

    typedef logic [HPDCACHE_ID_WIDTH-1:0] hpdcache_req_id_t;

    // Core operation carried through arbitration and replay
    typedef enum logic {
        HPDCACHE_OP_LOAD  = 1'b0,
        HPDCACHE_OP_STORE = 1'b1
    } hpdcache_req_op_e;

    // Controller mode
    // Only MODE_RUN lets a new request into stage 1
    typedef enum logic [1:0] {
        MODE_INIT_START  = 2'b00,
        MODE_INIT_WAIT   = 2'b01,
        MODE_RUN         = 2'b10,
        MODE_MISS_HAZARD = 2'b11
    } hpdcache_mode_e;

endpackage

/* verilog/hpdcache_wait_timer.sv */
module hpdcache_wait_timer #(
    parameter int unsigned WAIT_CYCLES = 8
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic start_i,
    output logic expired_o
);

    localparam int unsigned CNT_WIDTH = $clog2(WAIT_CYCLES + 1);

    // Cycles left before expiry
    // Zero means expired and holds there
    logic [CNT_WIDTH-1:0] cnt_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            // Nothing to wait for out of reset
            cnt_q <= '0;
        end else if (start_i) begin
            // The start cycle itself is the first waited cycle
            cnt_q <= CNT_WIDTH'(WAIT_CYCLES - 1);
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign expired_o = (cnt_q == '0);

    // Every rise of the expiry traces back to a start exactly WAIT_CYCLES earlier
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(expired_o) |-> $past(start_i, WAIT_CYCLES));

endmodule

/* verilog/hpdcache_ctrl_fsm.sv */
module hpdcache_ctrl_fsm (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         init_done_i,
    input  logic                         mshr_alloc_i,
    output logic                         init_start_o,
    output hpdcache_pkg::hpdcache_mode_e mode_o
);

    hpdcache_pkg::hpdcache_mode_e mode_q;
    hpdcache_pkg::hpdcache_mode_e mode_d;

    always_comb begin
        mode_d = mode_q;
        case (mode_q)
            // Single cycle to kick the init timer
            hpdcache_pkg::MODE_INIT_START: begin
                mode_d = hpdcache_pkg::MODE_INIT_WAIT;
            end
            // Cache RAMs being cleared
            hpdcache_pkg::MODE_INIT_WAIT: begin
                if (init_done_i) begin
                    mode_d = hpdcache_pkg::MODE_RUN;
                end
            end
            // A fresh MSHR entry blocks the next grant
            hpdcache_pkg::MODE_RUN: begin
                if (mshr_alloc_i) begin
                    mode_d = hpdcache_pkg::MODE_MISS_HAZARD;
                end
            end
            default: begin
                mode_d = hpdcache_pkg::MODE_RUN;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mode_q <= hpdcache_pkg::MODE_INIT_START;
        end else begin
            mode_q <= mode_d;
        end
    end

    assign init_start_o = (mode_q == hpdcache_pkg::MODE_INIT_START);
    assign mode_o       = mode_q;

    // The pe never allocates inside the bubble, so the bubble is one cycle long
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (mode_q == hpdcache_pkg::MODE_MISS_HAZARD) |->
            !mshr_alloc_i ##1 (mode_q != hpdcache_pkg::MODE_MISS_HAZARD));

endmodule

/* verilog/hpdcache_rtab.sv */
module hpdcache_rtab #(
    parameter int unsigned RTAB_DEPTH = 4
) (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           push_i,
    input  hpdcache_pkg::hpdcache_req_op_e push_op_i,
    input  hpdcache_pkg::hpdcache_req_id_t push_id_i,
    input  logic                           push_need_rsp_i,
    input  logic                           pop_i,
    output hpdcache_pkg::hpdcache_req_op_e head_op_o,
    output hpdcache_pkg::hpdcache_req_id_t head_id_o,
    output logic                           head_need_rsp_o,
    output logic                           empty_o,
    output logic                           full_o
);

    localparam int unsigned PTR_WIDTH = (RTAB_DEPTH > 1) ? $clog2(RTAB_DEPTH) : 1;
    localparam int unsigned CNT_WIDTH = $clog2(RTAB_DEPTH + 1);

    // On-hold request storage
    hpdcache_pkg::hpdcache_req_op_e op_q       [RTAB_DEPTH];
    hpdcache_pkg::hpdcache_req_id_t id_q       [RTAB_DEPTH];
    logic                           need_rsp_q [RTAB_DEPTH];

    logic [PTR_WIDTH-1:0] wr_ptr_q;
    logic [PTR_WIDTH-1:0] rd_ptr_q;
    logic [CNT_WIDTH-1:0] cnt_q;

    // Wrap at depth since depth need not be a power of two
    function automatic logic [PTR_WIDTH-1:0] ptr_next(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(RTAB_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            // Occupancy unchanged on push with pop
            case ({push_i, pop_i})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    // Rolled-back requests land at the tail like new ones
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            op_q[wr_ptr_q]       <= push_op_i;
            id_q[wr_ptr_q]       <= push_id_i;
            need_rsp_q[wr_ptr_q] <= push_need_rsp_i;
        end
    end

    // Head seen in the same cycle by the arbiter
    assign head_op_o       = op_q[rd_ptr_q];
    assign head_id_o       = id_q[rd_ptr_q];
    assign head_need_rsp_o = need_rsp_q[rd_ptr_q];
    assign empty_o         = (cnt_q == '0);
    assign full_o          = (cnt_q == CNT_WIDTH'(RTAB_DEPTH));

    assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full_o);
    assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> !empty_o);

endmodule

/* verilog/hpdcache_ctrl_pe.sv */
module hpdcache_ctrl_pe (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  hpdcache_pkg::hpdcache_mode_e   mode_i,
    // Core request port
    input  logic                           core_req_valid_i,
    input  hpdcache_pkg::hpdcache_req_op_e core_req_op_i,
    input  hpdcache_pkg::hpdcache_req_id_t core_req_id_i,
    input  logic                           core_req_need_rsp_i,
    output logic                           core_req_ready_o,
    // Replay table head
    input  hpdcache_pkg::hpdcache_req_op_e rtab_head_op_i,
    input  hpdcache_pkg::hpdcache_req_id_t rtab_head_id_i,
    input  logic                           rtab_head_need_rsp_i,
    input  logic                           rtab_eligible_i,
    input  logic                           rtab_full_i,
    output logic                           rtab_pop_o,
    // Replay table tail
    output logic                           rtab_push_o,
    output hpdcache_pkg::hpdcache_req_op_e rtab_push_op_o,
    output hpdcache_pkg::hpdcache_req_id_t rtab_push_id_o,
    output logic                           rtab_push_need_rsp_o,
    // Stage 1 lookup
    output logic                           st1_req_valid_o,
    output hpdcache_pkg::hpdcache_req_id_t st1_req_id_o,
    input  logic                           st1_dir_hit_i,
    input  logic                           st1_mshr_hit_i,
    input  logic                           st1_mshr_full_i,
    input  logic                           mshr_alloc_ready_i,
    input  logic                           wbuf_write_ready_i,
    // Results
    output logic                           rsp_valid_o,
    output hpdcache_pkg::hpdcache_req_id_t rsp_id_o,
    output logic                           mshr_alloc_o,
    output hpdcache_pkg::hpdcache_req_id_t mshr_alloc_id_o,
    output logic                           wbuf_write_valid_o,
    output hpdcache_pkg::hpdcache_req_id_t wbuf_write_id_o,
    // Events
    output logic                           evt_read_o,
    output logic                           evt_write_o,
    output logic                           evt_miss_o,
    output logic                           evt_hold_o,
    output logic                           evt_stall_o
);

    // Stage 1 register
    logic                           st1_valid_q;
    hpdcache_pkg::hpdcache_req_op_e st1_op_q;
    hpdcache_pkg::hpdcache_req_id_t st1_id_q;
    logic                           st1_need_rsp_q;

    logic st1_hold;
    logic cand_is_load;
    logic grant_ok;
    logic grant;

    // Stage 1 decision picks one disposition per request
    always_comb begin
        rsp_valid_o        = 1'b0;
        mshr_alloc_o       = 1'b0;
        wbuf_write_valid_o = 1'b0;
        st1_hold           = 1'b0;
        evt_read_o         = 1'b0;
        evt_write_o        = 1'b0;
        evt_miss_o         = 1'b0;
        if (st1_valid_q) begin
            if (st1_op_q == hpdcache_pkg::HPDCACHE_OP_LOAD) begin
                if (st1_dir_hit_i) begin
                    rsp_valid_o = st1_need_rsp_q;
                    evt_read_o  = 1'b1;
                end else if (st1_mshr_hit_i || st1_mshr_full_i || !mshr_alloc_ready_i ||
                             mode_i == hpdcache_pkg::MODE_MISS_HAZARD) begin
                    // In the bubble the MSHR lookup missed last cycle's allocation
                    st1_hold = 1'b1;
                end else begin
                    // Miss goes out and the response comes with the refill
                    mshr_alloc_o = 1'b1;
                    evt_read_o   = 1'b1;
                    evt_miss_o   = 1'b1;
                end
            end else begin
                // Store waits behind a pending miss on its line
                if (st1_mshr_hit_i || !wbuf_write_ready_i) begin
                    st1_hold = 1'b1;
                end else begin
                    wbuf_write_valid_o = 1'b1;
                    rsp_valid_o        = st1_need_rsp_q;
                    evt_write_o        = 1'b1;
                    evt_miss_o         = !st1_dir_hit_i;
                end
            end
        end
    end

    // Replay head goes before the core as next stage 1 candidate
    assign cand_is_load = rtab_eligible_i ? (rtab_head_op_i == hpdcache_pkg::HPDCACHE_OP_LOAD)
                                          : (core_req_op_i == hpdcache_pkg::HPDCACHE_OP_LOAD);

    // Store writes the data RAM this cycle so a load cannot read it
    assign grant_ok = (mode_i == hpdcache_pkg::MODE_RUN) && !st1_hold &&
                      !(wbuf_write_valid_o && cand_is_load);

    assign rtab_pop_o = grant_ok && rtab_eligible_i;

    // A held core request needs a free slot in the table
    assign core_req_ready_o = grant_ok && !rtab_eligible_i && core_req_valid_i && !rtab_full_i;

    assign grant = rtab_pop_o || core_req_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            st1_valid_q <= 1'b0;
        end else begin
            st1_valid_q <= grant;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rtab_pop_o) begin
            st1_op_q       <= rtab_head_op_i;
            st1_id_q       <= rtab_head_id_i;
            st1_need_rsp_q <= rtab_head_need_rsp_i;
        end else if (core_req_ready_o) begin
            st1_op_q       <= core_req_op_i;
            st1_id_q       <= core_req_id_i;
            st1_need_rsp_q <= core_req_need_rsp_i;
        end
    end

    // Held request goes back to the tail
    assign rtab_push_o          = st1_hold;
    assign rtab_push_op_o       = st1_op_q;
    assign rtab_push_id_o       = st1_id_q;
    assign rtab_push_need_rsp_o = st1_need_rsp_q;

    assign st1_req_valid_o = st1_valid_q;
    assign st1_req_id_o    = st1_id_q;
    assign rsp_id_o        = st1_id_q;
    assign mshr_alloc_id_o = st1_id_q;
    assign wbuf_write_id_o = st1_id_q;

    assign evt_hold_o  = st1_hold;
    assign evt_stall_o = core_req_valid_i && !core_req_ready_o;

    // Allocation opens the hazard, then stage 1 drains
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mshr_alloc_o |=> (mode_i == hpdcache_pkg::MODE_MISS_HAZARD) ##1 !st1_req_valid_o);

endmodule

/* verilog/hpdcache_perf_counters.sv */
module hpdcache_perf_counters #(
    parameter int unsigned PERF_CNT_WIDTH = 16
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      evt_read_i,
    input  logic                      evt_write_i,
    input  logic                      evt_miss_i,
    input  logic                      evt_hold_i,
    input  logic                      evt_stall_i,
    output logic [PERF_CNT_WIDTH-1:0] cnt_read_o,
    output logic [PERF_CNT_WIDTH-1:0] cnt_write_o,
    output logic [PERF_CNT_WIDTH-1:0] cnt_miss_o,
    output logic [PERF_CNT_WIDTH-1:0] cnt_hold_o,
    output logic [PERF_CNT_WIDTH-1:0] cnt_stall_o
);

    localparam int unsigned NB_EVT = 5;

    logic [NB_EVT-1:0]         evt;
    logic [PERF_CNT_WIDTH-1:0] cnt_q [NB_EVT];

    // Bit order matches the output list
    assign evt = {evt_stall_i, evt_hold_i, evt_miss_i, evt_write_i, evt_read_i};

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NB_EVT; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            // Stick at all ones instead of wrapping
            for (int i = 0; i < NB_EVT; i++) begin
                if (evt[i] && !(&cnt_q[i])) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    assign cnt_read_o  = cnt_q[0];
    assign cnt_write_o = cnt_q[1];
    assign cnt_miss_o  = cnt_q[2];
    assign cnt_hold_o  = cnt_q[3];
    assign cnt_stall_o = cnt_q[4];

endmodule

/* verilog/hpdcache_ctrl.sv */
module hpdcache_ctrl #(
    parameter int unsigned RTAB_DEPTH     = 4,
    parameter int unsigned RETRY_CYCLES   = 8,
    parameter int unsigned INIT_CYCLES    = 16,
    parameter int unsigned PERF_CNT_WIDTH = 16
) (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    // Core request port
    input  logic                           core_req_valid_i,
    input  hpdcache_pkg::hpdcache_req_op_e core_req_op_i,
    input  hpdcache_pkg::hpdcache_req_id_t core_req_id_i,
    input  logic                           core_req_need_rsp_i,
    output logic                           core_req_ready_o,
    // Stage 1 lookup
    output logic                           st1_req_valid_o,
    output hpdcache_pkg::hpdcache_req_id_t st1_req_id_o,
    input  logic                           st1_dir_hit_i,
    input  logic                           st1_mshr_hit_i,
    input  logic                           st1_mshr_full_i,
    input  logic                           mshr_alloc_ready_i,
    input  logic                           wbuf_write_ready_i,
    // Results
    output logic                           rsp_valid_o,
    output hpdcache_pkg::hpdcache_req_id_t rsp_id_o,
    output logic                           mshr_alloc_o,
    output hpdcache_pkg::hpdcache_req_id_t mshr_alloc_id_o,
    output logic                           wbuf_write_valid_o,
    output hpdcache_pkg::hpdcache_req_id_t wbuf_write_id_o,
    // Counters
    output logic [PERF_CNT_WIDTH-1:0]      cnt_read_o,
    output logic [PERF_CNT_WIDTH-1:0]      cnt_write_o,
    output logic [PERF_CNT_WIDTH-1:0]      cnt_miss_o,
    output logic [PERF_CNT_WIDTH-1:0]      cnt_hold_o,
    output logic [PERF_CNT_WIDTH-1:0]      cnt_stall_o
);

    hpdcache_pkg::hpdcache_mode_e   mode;
    logic                           init_start, init_done;
    logic                           rtab_push, rtab_pop, rtab_empty, rtab_full;
    logic                           rtab_eligible, retry_expired;
    hpdcache_pkg::hpdcache_req_op_e rtab_push_op, rtab_head_op;
    hpdcache_pkg::hpdcache_req_id_t rtab_push_id, rtab_head_id;
    logic                           rtab_push_need_rsp, rtab_head_need_rsp;
    logic                           evt_read, evt_write, evt_miss, evt_hold, evt_stall;

    hpdcache_ctrl_fsm i_ctrl_fsm (
        .clk_i, .rst_n_i,
        .init_done_i (init_done), .mshr_alloc_i (mshr_alloc_o),
        .init_start_o(init_start), .mode_o(mode)
    );

    hpdcache_wait_timer #(.WAIT_CYCLES(INIT_CYCLES)) i_init_timer (
        .clk_i, .rst_n_i, .start_i(init_start), .expired_o(init_done)
    );

    // Each push pushes back replay of the whole table
    hpdcache_wait_timer #(.WAIT_CYCLES(RETRY_CYCLES)) i_retry_timer (
        .clk_i, .rst_n_i, .start_i(rtab_push), .expired_o(retry_expired)
    );

    assign rtab_eligible = !rtab_empty && retry_expired;

    hpdcache_rtab #(.RTAB_DEPTH(RTAB_DEPTH)) i_rtab (
        .clk_i, .rst_n_i,
        .push_i(rtab_push), .push_op_i(rtab_push_op), .push_id_i(rtab_push_id),
        .push_need_rsp_i(rtab_push_need_rsp), .pop_i(rtab_pop),
        .head_op_o(rtab_head_op), .head_id_o(rtab_head_id),
        .head_need_rsp_o(rtab_head_need_rsp), .empty_o(rtab_empty), .full_o(rtab_full)
    );

    hpdcache_ctrl_pe i_ctrl_pe (
        .clk_i, .rst_n_i, .mode_i(mode),
        .core_req_valid_i, .core_req_op_i, .core_req_id_i, .core_req_need_rsp_i,
        .core_req_ready_o,
        .rtab_head_op_i(rtab_head_op), .rtab_head_id_i(rtab_head_id),
        .rtab_head_need_rsp_i(rtab_head_need_rsp), .rtab_eligible_i(rtab_eligible),
        .rtab_full_i(rtab_full), .rtab_pop_o(rtab_pop),
        .rtab_push_o(rtab_push), .rtab_push_op_o(rtab_push_op),
        .rtab_push_id_o(rtab_push_id), .rtab_push_need_rsp_o(rtab_push_need_rsp),
        .st1_req_valid_o, .st1_req_id_o,
        .st1_dir_hit_i, .st1_mshr_hit_i, .st1_mshr_full_i, .mshr_alloc_ready_i,
        .wbuf_write_ready_i,
        .rsp_valid_o, .rsp_id_o, .mshr_alloc_o, .mshr_alloc_id_o,
        .wbuf_write_valid_o, .wbuf_write_id_o,
        .evt_read_o(evt_read), .evt_write_o(evt_write), .evt_miss_o(evt_miss),
        .evt_hold_o(evt_hold), .evt_stall_o(evt_stall)
    );

    hpdcache_perf_counters #(.PERF_CNT_WIDTH(PERF_CNT_WIDTH)) i_perf_counters (
        .clk_i, .rst_n_i,
        .evt_read_i(evt_read), .evt_write_i(evt_write), .evt_miss_i(evt_miss),
        .evt_hold_i(evt_hold), .evt_stall_i(evt_stall),
        .cnt_read_o, .cnt_write_o, .cnt_miss_o, .cnt_hold_o, .cnt_stall_o
    );

endmodule

/* sim/hpdcache_ctrl_model.svh */
`ifndef HPDCACHE_CTRL_MODEL_SVH
`define HPDCACHE_CTRL_MODEL_SVH

// One request as the model sees it in stage 1 and in the replay FIFO
typedef struct packed {
    hpdcache_pkg::hpdcache_req_op_e op;
    logic                           need_rsp;
    hpdcache_pkg::hpdcache_req_id_t id;
} entry_t;

logic [31:0]               rng;
int unsigned               init_left;
int unsigned               retry_left;
bit                        hazard;
entry_t                    rtab_q[$];
bit                        st1_valid;
entry_t                    st1_entry;
int unsigned               sent_cnt;
int unsigned               done_cnt;
bit                        core_acc;
// Expected event counts in the DUT order read write miss hold stall
logic [PERF_CNT_WIDTH-1:0] exp_cnt [5];

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "Run stopped at first error");
endtask

task automatic check_bit(input string name, input logic got, input logic expected);
    if (got !== expected) begin
        report_error($sformatf("MISMATCH t=%0t %s: got %b expected %b",
                               $time, name, got, expected));
    end
endtask

task automatic check_id(input string name, input hpdcache_pkg::hpdcache_req_id_t got,
                        input hpdcache_pkg::hpdcache_req_id_t expected);
    if (got !== expected) begin
        report_error($sformatf("MISMATCH t=%0t %s: got %0h expected %0h",
                               $time, name, got, expected));
    end
endtask

task automatic check_cnt(input string name, input logic [PERF_CNT_WIDTH-1:0] got,
                         input logic [PERF_CNT_WIDTH-1:0] expected);
    if (got !== expected) begin
        report_error($sformatf("MISMATCH t=%0t %s: got %0d expected %0d",
                               $time, name, got, expected));
    end
endtask

// Saturating like the DUT counters
task automatic count_event(input int idx);
    if (!(&exp_cnt[idx])) begin
        exp_cnt[idx] = exp_cnt[idx] + 1'b1;
    end
endtask

// Mostly permissive status so that held requests drain
task automatic draw_status();
    rng = xorshift32(rng);
    st1_dir_hit_i      = rng[0];
    st1_mshr_hit_i     = (rng[3:1] == 3'd0);
    st1_mshr_full_i    = (rng[6:4] == 3'd0);
    mshr_alloc_ready_i = (rng[9:7] != 3'd0);
    wbuf_write_ready_i = (rng[12:10] != 3'd0);
endtask

`endif

/* sim/tb_hpdcache_ctrl.sv */
module tb_hpdcache_ctrl;

    localparam int unsigned RTAB_DEPTH     = 4;
    localparam int unsigned RETRY_CYCLES   = 8;
    localparam int unsigned INIT_CYCLES    = 16;
    localparam int unsigned PERF_CNT_WIDTH = 16;
    localparam int unsigned NB_REQ         = 300;
    localparam int unsigned CLK_PERIOD     = 20;
    localparam int unsigned DRV_DELAY      = 1;
    localparam int unsigned WATCHDOG_TIME  =
        (NB_REQ * (RETRY_CYCLES + 4) + INIT_CYCLES) * CLK_PERIOD;

    logic                           clk_i, rst_n_i;
    logic                           core_req_valid_i, core_req_need_rsp_i, core_req_ready_o;
    hpdcache_pkg::hpdcache_req_op_e core_req_op_i;
    hpdcache_pkg::hpdcache_req_id_t core_req_id_i, st1_req_id_o;
    hpdcache_pkg::hpdcache_req_id_t rsp_id_o, mshr_alloc_id_o, wbuf_write_id_o;
    logic                           st1_req_valid_o, st1_dir_hit_i, st1_mshr_hit_i;
    logic                           st1_mshr_full_i, mshr_alloc_ready_i, wbuf_write_ready_i;
    logic                           rsp_valid_o, mshr_alloc_o, wbuf_write_valid_o;
    logic [PERF_CNT_WIDTH-1:0]      cnt_read_o, cnt_write_o, cnt_miss_o;
    logic [PERF_CNT_WIDTH-1:0]      cnt_hold_o, cnt_stall_o;

    `include "hpdcache_ctrl_model.svh"

    hpdcache_ctrl #(
        .RTAB_DEPTH    (RTAB_DEPTH),
        .RETRY_CYCLES  (RETRY_CYCLES),
        .INIT_CYCLES   (INIT_CYCLES),
        .PERF_CNT_WIDTH(PERF_CNT_WIDTH)
    ) i_hpdcache_ctrl (.*);

    initial begin
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        report_error($sformatf("Timeout: only %0d of %0d requests completed", done_cnt, NB_REQ));
    end

    // Payload stays put until the model sees it accepted
    task automatic drive_core();
        if (core_acc) begin
            core_req_valid_i = 1'b0;
            core_acc         = 1'b0;
            sent_cnt++;
        end
        rng = xorshift32(rng);
        if (!core_req_valid_i && sent_cnt < NB_REQ && rng[1:0] != 2'd0) begin
            core_req_valid_i    = 1'b1;
            core_req_op_i       = rng[2] ? hpdcache_pkg::HPDCACHE_OP_STORE
                                         : hpdcache_pkg::HPDCACHE_OP_LOAD;
            // Ids wrap at 16 which is well above what can be in flight
            core_req_id_i       = hpdcache_pkg::hpdcache_req_id_t'(sent_cnt);
            core_req_need_rsp_i = rng[3];
        end
    endtask

    // Predict one cycle, compare, then step the model to the next cycle
    task automatic check_cycle();
        logic hold, rsp, alloc, wbuf, elig, cand_load, grant_ok, pop, ready;
        hold  = 1'b0;
        rsp   = 1'b0;
        alloc = 1'b0;
        wbuf  = 1'b0;
        if (st1_valid && st1_entry.op == hpdcache_pkg::HPDCACHE_OP_LOAD) begin
            if (st1_dir_hit_i) begin
                rsp = st1_entry.need_rsp;
                count_event(0);
            end else if (st1_mshr_hit_i || st1_mshr_full_i || !mshr_alloc_ready_i || hazard) begin
                hold = 1'b1;
            end else begin
                alloc = 1'b1;
                count_event(0);
                count_event(2);
            end
        end else if (st1_valid) begin
            if (st1_mshr_hit_i || !wbuf_write_ready_i) begin
                hold = 1'b1;
            end else begin
                wbuf = 1'b1;
                rsp  = st1_entry.need_rsp;
                count_event(1);
                if (!st1_dir_hit_i) begin
                    count_event(2);
                end
            end
        end
        // Replay head wins once its retry delay is over
        elig = (rtab_q.size() != 0) && (retry_left == 0);
        if (elig) begin
            cand_load = (rtab_q[0].op == hpdcache_pkg::HPDCACHE_OP_LOAD);
        end else begin
            cand_load = (core_req_op_i == hpdcache_pkg::HPDCACHE_OP_LOAD);
        end
        grant_ok = (init_left == 0) && !hazard && !hold && !(wbuf && cand_load);
        pop      = grant_ok && elig;
        ready    = grant_ok && !elig && core_req_valid_i && (rtab_q.size() < RTAB_DEPTH);
        if (hold) begin
            count_event(3);
        end
        if (core_req_valid_i && !ready) begin
            count_event(4);
        end
        check_bit("core_req_ready_o", core_req_ready_o, ready);
        check_bit("st1_req_valid_o", st1_req_valid_o, st1_valid);
        check_bit("rsp_valid_o", rsp_valid_o, rsp);
        check_bit("mshr_alloc_o", mshr_alloc_o, alloc);
        check_bit("wbuf_write_valid_o", wbuf_write_valid_o, wbuf);
        if (st1_valid) begin
            check_id("st1_req_id_o", st1_req_id_o, st1_entry.id);
        end
        if (rsp) begin
            check_id("rsp_id_o", rsp_id_o, st1_entry.id);
        end
        if (alloc) begin
            check_id("mshr_alloc_id_o", mshr_alloc_id_o, st1_entry.id);
        end
        if (wbuf) begin
            check_id("wbuf_write_id_o", wbuf_write_id_o, st1_entry.id);
        end
        // A request that is not held leaves stage 1 for good
        if (st1_valid && !hold) begin
            done_cnt++;
        end
        if (init_left != 0) begin
            init_left--;
        end
        hazard = alloc;
        if (hold) begin
            rtab_q.push_back(st1_entry);
            retry_left = RETRY_CYCLES - 1;
        end else if (retry_left != 0) begin
            retry_left--;
        end
        st1_valid = pop || ready;
        if (pop) begin
            st1_entry = rtab_q.pop_front();
        end else if (ready) begin
            st1_entry.op       = core_req_op_i;
            st1_entry.need_rsp = core_req_need_rsp_i;
            st1_entry.id       = core_req_id_i;
            core_acc           = 1'b1;
        end
    endtask

    initial begin
        rst_n_i             = 1'b0;
        core_req_valid_i    = 1'b0;
        core_req_op_i       = hpdcache_pkg::HPDCACHE_OP_LOAD;
        core_req_id_i       = '0;
        core_req_need_rsp_i = 1'b0;
        st1_dir_hit_i       = 1'b0;
        st1_mshr_hit_i      = 1'b0;
        st1_mshr_full_i     = 1'b0;
        mshr_alloc_ready_i  = 1'b0;
        wbuf_write_ready_i  = 1'b0;
        rng                 = 32'd87772;
        // INIT_START plus the INIT_WAIT cycles
        init_left           = INIT_CYCLES + 1;
        retry_left          = 0;
        hazard              = 1'b0;
        st1_valid           = 1'b0;
        sent_cnt            = 0;
        done_cnt            = 0;
        core_acc            = 1'b0;
        foreach (exp_cnt[i]) begin
            exp_cnt[i] = '0;
        end
        repeat (2) @(posedge clk_i);
        #(DRV_DELAY);
        rst_n_i = 1'b1;
        while (done_cnt < NB_REQ) begin
            drive_core();
            draw_status();
            @(negedge clk_i);
            check_cycle();
            @(posedge clk_i);
            #(DRV_DELAY);
        end
        // Let the last events reach the counters
        core_req_valid_i = 1'b0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        check_cnt("cnt_read_o", cnt_read_o, exp_cnt[0]);
        check_cnt("cnt_write_o", cnt_write_o, exp_cnt[1]);
        check_cnt("cnt_miss_o", cnt_miss_o, exp_cnt[2]);
        check_cnt("cnt_hold_o", cnt_hold_o, exp_cnt[3]);
        check_cnt("cnt_stall_o", cnt_stall_o, exp_cnt[4]);
        $display("Verification passed");
        $finish;
    end

endmodule

/* hpdcache_ctrl.f */
+incdir+sim
verilog/hpdcache_pkg.sv
verilog/hpdcache_wait_timer.sv
verilog/hpdcache_ctrl_fsm.sv
verilog/hpdcache_rtab.sv
verilog/hpdcache_ctrl_pe.sv
verilog/hpdcache_perf_counters.sv
verilog/hpdcache_ctrl.sv
sim/tb_hpdcache_ctrl.sv

/* Bender.yml */
package:
  name: hpdcache_ctrl

sources:
  - files:
      - verilog/hpdcache_pkg.sv
      - verilog/hpdcache_wait_timer.sv
      - verilog/hpdcache_ctrl_fsm.sv
      - verilog/hpdcache_rtab.sv
      - verilog/hpdcache_ctrl_pe.sv
      - verilog/hpdcache_perf_counters.sv
      - verilog/hpdcache_ctrl.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_hpdcache_ctrl.sv
